//--- src/core_ctrl_defs.svh
`ifndef CORE_CTRL_DEFS_SVH
`define CORE_CTRL_DEFS_SVH

// Descriptor beat width for header and DRAM address alike
`define DESC_WIDTH 64

// Packet slots tracked per core
// Slot 0 is never used, so the vector runs from 1 upward
`define SLOT_COUNT 32

// Width of the slot field in a descriptor header
`define SLOT_WIDTH 6

// Beats held between merger and output stage
`define DESC_FIFO_DEPTH 8

// Free-running timer loaded in two 32-bit halves
`define TIMER_WIDTH 64

`endif

//--- src/core_ctrl_pkg.sv
`include "core_ctrl_defs.svh"

package core_ctrl_pkg;

  // Descriptor type in header bits 63:60
  // Values 3 and 6 to 15 are reserved
  typedef enum logic [3:0] {
    DESC_DROP    = 4'd0,
    DESC_SEND    = 4'd1,
    DESC_TO_CORE = 4'd2,
    DESC_DRAM_WR = 4'd4,
    DESC_DRAM_RD = 4'd5
  } desc_type_e;

  // Slot number starts at header bit 16
  localparam int SLOT_LSB = 16;

  // Wrapper status channel address
  typedef enum logic [2:0] {
    STS_CFG      = 3'd0,
    STS_TIMER_LO = 3'd1,
    STS_TIMER_HI = 3'd2,
    STS_IRQ      = 3'd3,
    STS_DEBUG_LO = 3'd4,
    STS_DEBUG_HI = 3'd5,
    STS_COUNTS   = 3'd6
  } status_addr_e;

  typedef struct packed {
    logic [7:0]  core_id;
    logic [7:0]  max_slot_count;
    logic [15:0] bc_region_size;
  } status_cfg_t;

  typedef struct packed {
    logic [9:0]  spare_hi;
    logic        tag_valid;
    logic        dupl_slot;
    logic        inv_slot;
    logic        inv_desc;
    logic        poke;
    logic        evict;
    logic [10:0] spare_lo;
    logic [4:0]  dram_tag;
  } status_irq_t;

  typedef struct packed {
    logic [7:0] core_msg;
    logic [7:0] dram_req;
    logic [7:0] dram_send;
    logic [7:0] send_data;
  } status_counts_t;

  // One status word, read through the view that its address selects
  typedef union packed {
    status_cfg_t    cfg;
    status_irq_t    irq;
    status_counts_t counts;
    logic [31:0]    raw;
  } status_word_u;

  function automatic desc_type_e hdr_type(logic [`DESC_WIDTH-1:0] hdr);
    return desc_type_e'(hdr[63:60]);
  endfunction

  // DRAM descriptors carry an address beat after the header
  function automatic logic is_dram_type(desc_type_e t);
    return (t == DESC_DRAM_WR) || (t == DESC_DRAM_RD);
  endfunction

  // These types finish the packet held in the slot
  function automatic logic frees_slot(desc_type_e t);
    return (t == DESC_DROP) || (t == DESC_SEND) || (t == DESC_TO_CORE);
  endfunction

endpackage

//--- src/desc_if.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

// One descriptor beat with valid/ready handshake
// Data and second hold from valid until the transfer
interface desc_if;

  logic [`DESC_WIDTH-1:0] data;
  logic                   second;
  logic                   valid;
  logic                   ready;

  modport producer (
    output data,
    output second,
    output valid,
    input  ready
  );

  modport consumer (
    input  data,
    input  second,
    input  valid,
    output ready
  );

endinterface

//--- src/desc_merger.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module desc_merger import core_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_reset,
  input  logic [`DESC_WIDTH-1:0] core_desc_hdr,
  input  logic [`DESC_WIDTH-1:0] core_desc_dram_addr,
  input  logic                   core_desc_valid,
  output logic                   core_desc_ready,
  desc_if.producer               beat
);

  // Low while the header goes out, high for the DRAM address beat
  logic addr_phase;
  logic dram_desc;
  logic beat_xfer;

  assign dram_desc = is_dram_type(hdr_type(core_desc_hdr));
  assign beat_xfer = beat.valid && beat.ready;

  //////////////////////////////////////////////////////////////
  // Beat selection
  //////////////////////////////////////////////////////////////

  assign beat.valid  = core_desc_valid;
  assign beat.data   = addr_phase ? core_desc_dram_addr : core_desc_hdr;
  assign beat.second = addr_phase;

  // Core is released only once the last beat of its descriptor goes
  assign core_desc_ready = (!addr_phase && dram_desc) ? 1'b0 : beat.ready;

  //////////////////////////////////////////////////////////////
  // Header / address state
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_phase <= 1'b0;
    end else if (core_reset) begin
      addr_phase <= 1'b0;
    end else if (beat_xfer) begin
      addr_phase <= !addr_phase && dram_desc;
    end
  end

  // The core has to keep its header until it is released
  a_hdr_stable: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    core_desc_valid && !core_desc_ready |=> $stable(core_desc_hdr)
  ) else $error("core_desc_hdr changed before core_desc_ready");

endmodule

//--- src/desc_fifo.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module desc_fifo (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     core_reset,
  desc_if.consumer wr,
  desc_if.producer rd
);

  localparam int DEPTH = `DESC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Beat storage
  logic [`DESC_WIDTH-1:0] data_mem   [DEPTH];
  logic                   second_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CNT_W'(DEPTH));
  assign pop  = rd.valid && rd.ready;
  assign push = wr.valid && wr.ready;

  // A full FIFO still takes a beat in the cycle it hands one out
  assign wr.ready  = !full || pop;
  assign rd.valid  = (count != '0);
  assign rd.data   = data_mem[rd_ptr];
  assign rd.second = second_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr]   <= wr.data;
      second_mem[wr_ptr] <= wr.second;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (core_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // A full FIFO that is not read keeps its write pointer on the oldest beat
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    full && !pop |=> full && (wr_ptr == rd_ptr)
  ) else $error("full FIFO lost its oldest beat");

  a_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH)
  ) else $error("FIFO count above depth");

endmodule

//--- src/desc_out_slots.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module desc_out_slots import core_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   core_reset,
  input  logic [`DESC_WIDTH-1:0] in_desc,
  input  logic                   in_desc_valid,
  input  logic                   in_desc_taken,
  output logic [`DESC_WIDTH-1:0] out_desc,
  output logic                   out_desc_2nd,
  output logic                   out_desc_valid,
  input  logic                   out_desc_ready,
  output logic [`SLOT_COUNT:1]   slots_in_prog,
  desc_if.consumer               beat
);

  logic [`SLOT_WIDTH-1:0] in_slot;
  logic [`SLOT_WIDTH-1:0] out_slot;
  logic                   set_en;
  logic                   clr_en;
  logic [`SLOT_COUNT:1]   set_mask;
  logic [`SLOT_COUNT:1]   clr_mask;

  //////////////////////////////////////////////////////////////
  // Wrapper side
  //////////////////////////////////////////////////////////////

  assign out_desc       = beat.data;
  assign out_desc_2nd   = beat.second;
  assign out_desc_valid = beat.valid;
  assign beat.ready     = out_desc_ready;

  //////////////////////////////////////////////////////////////
  // Slots in progress
  //////////////////////////////////////////////////////////////

  assign in_slot  = in_desc[SLOT_LSB +: `SLOT_WIDTH];
  assign out_slot = out_desc[SLOT_LSB +: `SLOT_WIDTH];
  assign set_en   = in_desc_valid && in_desc_taken;
  // Only a first beat holds a type so address beats are skipped
  assign clr_en   = out_desc_valid && out_desc_ready && !out_desc_2nd &&
                    frees_slot(hdr_type(out_desc));

  always_comb begin
    for (int i = 1; i <= `SLOT_COUNT; i++) begin
      set_mask[i] = set_en && (in_slot == `SLOT_WIDTH'(i));
      clr_mask[i] = clr_en && (out_slot == `SLOT_WIDTH'(i));
    end
  end

  // Clear wins over a set of the same slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots_in_prog <= '0;
    end else if (core_reset) begin
      slots_in_prog <= '0;
    end else begin
      slots_in_prog <= (slots_in_prog | set_mask) & ~clr_mask;
    end
  end

  a_no_slot_zero: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    !(set_en && in_slot == '0) && !(clr_en && out_slot == '0)
  ) else $error("descriptor refers to slot 0");

endmodule

//--- src/status_decoder.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module status_decoder import core_ctrl_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    core_reset,
  input  logic [31:0]             wrapper_status_data,
  input  logic [2:0]              wrapper_status_addr,
  output logic [15:0]             bc_region_size,
  output logic [7:0]              core_id,
  output logic [7:0]              max_slot_count,
  output logic [7:0]              send_data_items,
  output logic [7:0]              dram_send_items,
  output logic [7:0]              dram_req_items,
  output logic [7:0]              core_msg_items,
  output logic [`TIMER_WIDTH-1:0] timer,
  output logic [4:0]              recv_dram_tag,
  output logic                    recv_dram_tag_v,
  output logic                    evict_int,
  input  logic                    evict_int_ack,
  output logic                    poke_int,
  input  logic                    poke_int_ack,
  output logic                    dupl_slot_int,
  input  logic                    dupl_slot_int_ack,
  output logic                    inv_slot_int,
  input  logic                    inv_slot_int_ack,
  output logic                    inv_desc_int,
  input  logic                    inv_desc_int_ack
);

  localparam int HALF = `TIMER_WIDTH / 2;

  status_word_u sw;
  status_addr_e addr;
  logic         irq_wr;
  // Bits from dupl_slot at the top down to evict
  logic [4:0]   int_q;
  logic [4:0]   int_set;
  logic [4:0]   int_ack;

  assign sw.raw = wrapper_status_data;
  assign addr   = status_addr_e'(wrapper_status_addr);
  assign irq_wr = (addr == STS_IRQ);

  //////////////////////////////////////////////////////////////
  // Configuration and work counters
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n || core_reset) begin
      core_id         <= '0;
      max_slot_count  <= '0;
      bc_region_size  <= '0;
      core_msg_items  <= '0;
      dram_req_items  <= '0;
      dram_send_items <= '0;
      send_data_items <= '0;
    end else begin
      case (addr)
        STS_CFG: begin
          core_id        <= sw.cfg.core_id;
          max_slot_count <= sw.cfg.max_slot_count;
          bc_region_size <= sw.cfg.bc_region_size;
        end
        STS_COUNTS: begin
          core_msg_items  <= sw.counts.core_msg;
          dram_req_items  <= sw.counts.dram_req;
          dram_send_items <= sw.counts.dram_send;
          send_data_items <= sw.counts.send_data;
        end
        default: begin
        end
      endcase
    end
  end

  // A half write replaces the increment for that cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n || core_reset) begin
      timer <= '0;
    end else if (addr == STS_TIMER_LO) begin
      timer <= {timer[`TIMER_WIDTH-1:HALF], sw.raw};
    end else if (addr == STS_TIMER_HI) begin
      timer <= {sw.raw, timer[HALF-1:0]};
    end else begin
      timer <= timer + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Interrupts and DRAM tag
  //////////////////////////////////////////////////////////////

  assign int_set = irq_wr ? {sw.irq.dupl_slot, sw.irq.inv_slot, sw.irq.inv_desc,
                             sw.irq.poke, sw.irq.evict} : 5'b0;
  assign int_ack = {dupl_slot_int_ack, inv_slot_int_ack, inv_desc_int_ack,
                    poke_int_ack, evict_int_ack};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n || core_reset) begin
      int_q           <= '0;
      recv_dram_tag_v <= 1'b0;
    end else begin
      int_q           <= (int_q | int_set) & ~int_ack;
      recv_dram_tag_v <= irq_wr && sw.irq.tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (irq_wr && sw.irq.tag_valid) begin
      recv_dram_tag <= sw.irq.dram_tag;
    end
  end

  assign {dupl_slot_int, inv_slot_int, inv_desc_int, poke_int, evict_int} = int_q;

  a_tag_pulse: assert property (
    @(posedge clk) disable iff (!rst_n || core_reset)
    recv_dram_tag_v |=> !recv_dram_tag_v
  ) else $error("recv_dram_tag_v high for two cycles");

endmodule

//--- src/core_ctrl_top.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module core_ctrl_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    core_reset,
  // Core descriptors
  input  logic [`DESC_WIDTH-1:0]  core_desc_hdr,
  input  logic [`DESC_WIDTH-1:0]  core_desc_dram_addr,
  input  logic                    core_desc_valid,
  output logic                    core_desc_ready,
  // Wrapper descriptors
  output logic [`DESC_WIDTH-1:0]  out_desc,
  output logic                    out_desc_2nd,
  output logic                    out_desc_valid,
  input  logic                    out_desc_ready,
  // Incoming descriptor monitor
  input  logic [`DESC_WIDTH-1:0]  in_desc,
  input  logic                    in_desc_valid,
  input  logic                    in_desc_taken,
  output logic [`SLOT_COUNT:1]    slots_in_prog,
  // Wrapper status channel
  input  logic [31:0]             wrapper_status_data,
  input  logic [2:0]              wrapper_status_addr,
  output logic [15:0]             bc_region_size,
  output logic [7:0]              core_id,
  output logic [7:0]              max_slot_count,
  output logic [7:0]              send_data_items,
  output logic [7:0]              dram_send_items,
  output logic [7:0]              dram_req_items,
  output logic [7:0]              core_msg_items,
  output logic [`TIMER_WIDTH-1:0] timer,
  output logic [4:0]              recv_dram_tag,
  output logic                    recv_dram_tag_v,
  output logic                    evict_int,
  input  logic                    evict_int_ack,
  output logic                    poke_int,
  input  logic                    poke_int_ack,
  output logic                    dupl_slot_int,
  input  logic                    dupl_slot_int_ack,
  output logic                    inv_slot_int,
  input  logic                    inv_slot_int_ack,
  output logic                    inv_desc_int,
  input  logic                    inv_desc_int_ack
);

  desc_if merger_to_fifo ();
  desc_if fifo_to_out ();

  desc_merger u_desc_merger (
    .clk                 (clk),
    .rst_n               (rst_n),
    .core_reset          (core_reset),
    .core_desc_hdr       (core_desc_hdr),
    .core_desc_dram_addr (core_desc_dram_addr),
    .core_desc_valid     (core_desc_valid),
    .core_desc_ready     (core_desc_ready),
    .beat                (merger_to_fifo)
  );

  desc_fifo u_desc_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_reset (core_reset),
    .wr         (merger_to_fifo),
    .rd         (fifo_to_out)
  );

  desc_out_slots u_desc_out_slots (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_reset     (core_reset),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .in_desc_taken  (in_desc_taken),
    .out_desc       (out_desc),
    .out_desc_2nd   (out_desc_2nd),
    .out_desc_valid (out_desc_valid),
    .out_desc_ready (out_desc_ready),
    .slots_in_prog  (slots_in_prog),
    .beat           (fifo_to_out)
  );

  status_decoder u_status_decoder (
    .clk                 (clk),
    .rst_n               (rst_n),
    .core_reset          (core_reset),
    .wrapper_status_data (wrapper_status_data),
    .wrapper_status_addr (wrapper_status_addr),
    .bc_region_size      (bc_region_size),
    .core_id             (core_id),
    .max_slot_count      (max_slot_count),
    .send_data_items     (send_data_items),
    .dram_send_items     (dram_send_items),
    .dram_req_items      (dram_req_items),
    .core_msg_items      (core_msg_items),
    .timer               (timer),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_v     (recv_dram_tag_v),
    .evict_int           (evict_int),
    .evict_int_ack       (evict_int_ack),
    .poke_int            (poke_int),
    .poke_int_ack        (poke_int_ack),
    .dupl_slot_int       (dupl_slot_int),
    .dupl_slot_int_ack   (dupl_slot_int_ack),
    .inv_slot_int        (inv_slot_int),
    .inv_slot_int_ack    (inv_slot_int_ack),
    .inv_desc_int        (inv_desc_int),
    .inv_desc_int_ack    (inv_desc_int_ack)
  );

endmodule

//--- verification/core_ctrl_tb.sv
`timescale 1ns/100ps
`include "core_ctrl_defs.svh"

module core_ctrl_tb;

  localparam int TIMEOUT = 200;
  // Debug words are not decoded by the status decoder
  localparam logic [2:0] ADDR_IDLE = 3'd4;

  logic                    clk;
  logic                    rst_n;
  logic                    core_reset;
  logic [`DESC_WIDTH-1:0]  core_desc_hdr;
  logic [`DESC_WIDTH-1:0]  core_desc_dram_addr;
  logic                    core_desc_valid;
  logic                    core_desc_ready;
  logic [`DESC_WIDTH-1:0]  out_desc;
  logic                    out_desc_2nd;
  logic                    out_desc_valid;
  logic                    out_desc_ready;
  logic [`DESC_WIDTH-1:0]  in_desc;
  logic                    in_desc_valid;
  logic                    in_desc_taken;
  logic [`SLOT_COUNT:1]    slots_in_prog;
  logic [31:0]             wrapper_status_data;
  logic [2:0]              wrapper_status_addr;
  logic [15:0]             bc_region_size;
  logic [7:0]              core_id;
  logic [7:0]              max_slot_count;
  logic [7:0]              send_data_items;
  logic [7:0]              dram_send_items;
  logic [7:0]              dram_req_items;
  logic [7:0]              core_msg_items;
  logic [`TIMER_WIDTH-1:0] timer;
  logic [4:0]              recv_dram_tag;
  logic                    recv_dram_tag_v;
  logic                    evict_int;
  logic                    evict_int_ack;
  logic                    poke_int;
  logic                    poke_int_ack;
  logic                    dupl_slot_int;
  logic                    dupl_slot_int_ack;
  logic                    inv_slot_int;
  logic                    inv_slot_int_ack;
  logic                    inv_desc_int;
  logic                    inv_desc_int_ack;

  integer      seed;
  int          err_count;
  int          timeout_count;
  int          desc_wait;
  int          stall_cycles;
  int          blocked_cycles;
  bit          stall_block_seen;
  bit          sender_done;
  // Beats as {second, data}
  logic [64:0] got_q [$];
  logic [64:0] exp_q [$];

  core_ctrl_top u_core_ctrl_top (.*);

  always #20 clk = ~clk;

  // Output beat monitor
  always @(posedge clk) begin
    if (rst_n && out_desc_valid && out_desc_ready) begin
      got_q.push_back({out_desc_2nd, out_desc});
    end
  end

  // A full FIFO under a long stall has to hold off the core
  always @(posedge clk) begin
    if (out_desc_ready) begin
      stall_cycles = 0;
    end else begin
      stall_cycles = stall_cycles + 1;
    end
    // A DRAM header alone holds the core for one cycle only
    if (stall_cycles >= 10 && core_desc_valid && !core_desc_ready) begin
      blocked_cycles = blocked_cycles + 1;
    end else begin
      blocked_cycles = 0;
    end
    if (blocked_cycles >= 2) begin
      stall_block_seen = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    err_count++;
  endtask

  task automatic note_timeout(input string what);
    $display("Timed out waiting for %s", what);
    timeout_count++;
  endtask

  function automatic logic [63:0] make_hdr(input logic [3:0] dtype, input logic [5:0] slot);
    logic [63:0] h;
    h = {$random(seed), $random(seed)};
    h[63:60] = dtype;
    h[21:16] = slot;
    return h;
  endfunction

  // Header first, then the address for DRAM types 4 and 5
  task automatic expect_desc(input logic [63:0] hdr, input logic [63:0] addr);
    exp_q.push_back({1'b0, hdr});
    if (hdr[63:60] == 4'd4 || hdr[63:60] == 4'd5) begin
      exp_q.push_back({1'b1, addr});
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the release
  task automatic send_desc(input logic [63:0] hdr, input logic [63:0] addr);
    int cycles;
    cycles = 0;
    desc_wait = 0;
    core_desc_hdr = hdr;
    core_desc_dram_addr = addr;
    core_desc_valid = 1'b1;
    while (desc_wait == 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (core_desc_ready) desc_wait = cycles;
    end
    @(negedge clk);
    core_desc_valid = 1'b0;
    if (desc_wait == 0) note_timeout("core_desc_ready");
  endtask

  task automatic wait_beats(input int n);
    int cycles;
    cycles = 0;
    while (got_q.size() < n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (got_q.size() < n) note_timeout("output beats");
  endtask

  task automatic compare_beats();
    logic [64:0] g;
    logic [64:0] e;
    if (got_q.size() != exp_q.size()) begin
      $display("[ERROR] beat count: got 0x%0h, expected 0x%0h", got_q.size(), exp_q.size());
      err_count++;
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      if (g[63:0] !== e[63:0]) report_mismatch("out_desc", g[63:0], e[63:0]);
      if (g[64] !== e[64]) report_mismatch("out_desc_2nd", g[64], e[64]);
    end
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic take_slot(input logic [5:0] slot);
    in_desc = make_hdr(4'd2, slot);
    in_desc_valid = 1'b1;
    in_desc_taken = 1'b1;
    @(negedge clk);
    in_desc_valid = 1'b0;
    in_desc_taken = 1'b0;
  endtask

  task automatic write_status(input logic [2:0] addr, input logic [31:0] data);
    wrapper_status_addr = addr;
    wrapper_status_data = data;
    @(negedge clk);
    wrapper_status_addr = ADDR_IDLE;
  endtask

  function automatic logic [4:0] int_vec();
    return {dupl_slot_int, inv_slot_int, inv_desc_int, poke_int, evict_int};
  endfunction

  // Index follows int_vec with evict at 0 up to dupl_slot at 4
  task automatic pulse_ack(input int idx);
    evict_int_ack     = (idx == 0);
    poke_int_ack      = (idx == 1);
    inv_desc_int_ack  = (idx == 2);
    inv_slot_int_ack  = (idx == 3);
    dupl_slot_int_ack = (idx == 4);
    @(negedge clk);
    {evict_int_ack, poke_int_ack, inv_desc_int_ack, inv_slot_int_ack, dupl_slot_int_ack} = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_send_single();
    logic [63:0] hdr;
    hdr = make_hdr(4'd1, 6'd5);
    expect_desc(hdr, 64'h0);
    send_desc(hdr, 64'h0);
    if (desc_wait != 1) report_mismatch("core_desc_ready latency", desc_wait, 1);
    // First beat is at the output one cycle after the FIFO took it
    if (out_desc_valid !== 1'b1) report_mismatch("out_desc_valid", out_desc_valid, 1);
    if (out_desc !== hdr) report_mismatch("out_desc", out_desc, hdr);
    if (out_desc_2nd !== 1'b0) report_mismatch("out_desc_2nd", out_desc_2nd, 0);
    wait_beats(1);
    compare_beats();
  endtask

  task automatic test_dram_read();
    logic [63:0] hdr;
    logic [63:0] addr;
    hdr = make_hdr(4'd5, 6'd6);
    addr = {$random(seed), $random(seed)};
    expect_desc(hdr, addr);
    send_desc(hdr, addr);
    // Low during the header transfer, high with the address transfer
    if (desc_wait != 2) report_mismatch("core_desc_ready latency", desc_wait, 2);
    wait_beats(2);
    compare_beats();
  endtask

  task automatic toggle_ready();
    int n;
    integer rnd;
    n = 0;
    while (!sender_done && n < 2000) begin
      @(negedge clk);
      if (n % 40 == 5) begin
        out_desc_ready = 1'b0;
        repeat (14) @(negedge clk);
      end else begin
        rnd = $random(seed);
        out_desc_ready = rnd[0];
      end
      n++;
    end
    if (!sender_done) note_timeout("random descriptor sender");
  endtask

  task automatic test_random_stream();
    logic [63:0] hdr;
    logic [63:0] addr;
    int          idx;
    logic [3:0]  dtype;
    logic [5:0]  slot;
    sender_done = 1'b0;
    stall_block_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          idx = $unsigned($random(seed)) % 5;
          // Skip reserved type 3
          dtype = (idx < 3) ? 4'(idx) : 4'(idx + 1);
          slot = 6'(1 + $unsigned($random(seed)) % 31);
          hdr = make_hdr(dtype, slot);
          addr = {$random(seed), $random(seed)};
          expect_desc(hdr, addr);
          send_desc(hdr, addr);
        end
        sender_done = 1'b1;
      end
      toggle_ready();
    join
    out_desc_ready = 1'b1;
    wait_beats(exp_q.size());
    compare_beats();
    if (!stall_block_seen) begin
      $display("core_desc_ready never went low while the output was stalled");
      err_count++;
    end
  endtask

  task automatic test_slots();
    logic [`SLOT_COUNT:1] exp_slots;
    logic [63:0]          hdr;
    logic [63:0]          addr;
    take_slot(6'd3);
    take_slot(6'd7);
    exp_slots = '0;
    exp_slots[3] = 1'b1;
    exp_slots[7] = 1'b1;
    if (slots_in_prog !== exp_slots) report_mismatch("slots_in_prog", slots_in_prog, exp_slots);
    hdr = make_hdr(4'd1, 6'd3);
    expect_desc(hdr, 64'h0);
    send_desc(hdr, 64'h0);
    wait_beats(1);
    exp_slots[3] = 1'b0;
    if (slots_in_prog !== exp_slots) report_mismatch("slots_in_prog", slots_in_prog, exp_slots);
    // A DRAM write keeps its slot busy
    hdr = make_hdr(4'd4, 6'd7);
    addr = {$random(seed), $random(seed)};
    expect_desc(hdr, addr);
    send_desc(hdr, addr);
    wait_beats(3);
    if (slots_in_prog !== exp_slots) report_mismatch("slots_in_prog", slots_in_prog, exp_slots);
    compare_beats();
  endtask

  task automatic test_status();
    int k;
    k = 7;
    write_status(3'd0, 32'hA51F_1234);
    if (core_id !== 8'hA5) report_mismatch("core_id", core_id, 8'hA5);
    if (max_slot_count !== 8'h1F) report_mismatch("max_slot_count", max_slot_count, 8'h1F);
    if (bc_region_size !== 16'h1234) report_mismatch("bc_region_size", bc_region_size, 16'h1234);
    write_status(3'd6, 32'h1122_3344);
    if (core_msg_items !== 8'h11) report_mismatch("core_msg_items", core_msg_items, 8'h11);
    if (dram_req_items !== 8'h22) report_mismatch("dram_req_items", dram_req_items, 8'h22);
    if (dram_send_items !== 8'h33) report_mismatch("dram_send_items", dram_send_items, 8'h33);
    if (send_data_items !== 8'h44) report_mismatch("send_data_items", send_data_items, 8'h44);
    write_status(3'd1, 32'h0000_1000);
    repeat (k) @(negedge clk);
    if (timer[31:0] !== 32'h1000 + k) report_mismatch("timer", timer[31:0], 32'h1000 + k);
  endtask

  task automatic test_interrupts();
    logic [4:0] exp_ints;
    // tag_valid, dupl_slot, poke and evict with tag 0x15
    write_status(3'd3, 32'h0033_0015);
    if (recv_dram_tag_v !== 1'b1) report_mismatch("recv_dram_tag_v", recv_dram_tag_v, 1);
    if (recv_dram_tag !== 5'h15) report_mismatch("recv_dram_tag", recv_dram_tag, 5'h15);
    if (int_vec() !== 5'b10011) report_mismatch("interrupts", int_vec(), 5'b10011);
    @(negedge clk);
    if (recv_dram_tag_v !== 1'b0) report_mismatch("recv_dram_tag_v", recv_dram_tag_v, 0);
    write_status(3'd3, 32'h001F_0000);
    exp_ints = 5'b11111;
    if (int_vec() !== exp_ints) report_mismatch("interrupts", int_vec(), exp_ints);
    for (int i = 0; i < 5; i++) begin
      pulse_ack(i);
      exp_ints[i] = 1'b0;
      if (int_vec() !== exp_ints) report_mismatch("interrupts", int_vec(), exp_ints);
    end
    take_slot(6'd9);
    write_status(3'd3, 32'h003F_0009);
    // Park a beat at the stalled output
    out_desc_ready = 1'b0;
    send_desc(make_hdr(4'd1, 6'd9), 64'h0);
    // Reset lands together with another tagged irq write
    wrapper_status_addr = 3'd3;
    wrapper_status_data = 32'h003F_0009;
    core_reset = 1'b1;
    @(negedge clk);
    core_reset = 1'b0;
    wrapper_status_addr = ADDR_IDLE;
    out_desc_ready = 1'b1;
    if (int_vec() !== 5'b0) report_mismatch("interrupts", int_vec(), 0);
    if (recv_dram_tag_v !== 1'b0) report_mismatch("recv_dram_tag_v", recv_dram_tag_v, 0);
    if (slots_in_prog !== '0) report_mismatch("slots_in_prog", slots_in_prog, 0);
    if (timer !== '0) report_mismatch("timer", timer, 0);
    if (core_id !== 8'h0) report_mismatch("core_id", core_id, 0);
    if (out_desc_valid !== 1'b0) report_mismatch("out_desc_valid", out_desc_valid, 0);
  endtask

  initial begin
    seed = 97;
    err_count = 0;
    timeout_count = 0;
    stall_cycles = 0;
    blocked_cycles = 0;
    stall_block_seen = 1'b0;
    sender_done = 1'b0;
    clk = 1'b0;
    rst_n = 1'b0;
    core_reset = 1'b0;
    core_desc_hdr = '0;
    core_desc_dram_addr = '0;
    core_desc_valid = 1'b0;
    out_desc_ready = 1'b1;
    in_desc = '0;
    in_desc_valid = 1'b0;
    in_desc_taken = 1'b0;
    wrapper_status_data = '0;
    wrapper_status_addr = ADDR_IDLE;
    {evict_int_ack, poke_int_ack, inv_desc_int_ack, inv_slot_int_ack, dupl_slot_int_ack} = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_send_single();
    test_dram_read();
    test_random_stream();
    test_slots();
    test_status();
    test_interrupts();

    $display("Value errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/core_ctrl_pkg.sv
src/desc_if.sv
src/desc_merger.sv
src/desc_fifo.sv
src/desc_out_slots.sv
src/status_decoder.sv
src/core_ctrl_top.sv
verification/core_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the result

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_ctrl_tb -Mdir "$BUILD_DIR" -o core_ctrl_sim \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/core_ctrl_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  echo "Simulation PASS"
  exit 0
fi
echo "Simulation FAIL"
exit 1
